// File: rtl/filter_consts.svh
`ifndef FILTER_CONSTS_SVH
`define FILTER_CONSTS_SVH

// one RGB444 pixel per beat
`define FS_PIXEL_WIDTH 12

// bits per colour channel and number of lanes
`define FS_CHANNEL_WIDTH 4
`define FS_NUM_CHANNELS 3

// saturation value of a single channel
`define FS_CHANNEL_MAX 4'd15

`endif

// File: rtl/filter_pkg.sv
package filter_pkg;

	// filter selection in the same encoding as filter_num
	typedef enum logic [1:0] {
		COLOUR     = 2'b00,
		BLUR       = 2'b01,
		BRIGHTNESS = 2'b10,
		EDGES      = 2'b11
	} filter_mode_e;

endpackage

// File: rtl/frame_control.sv
`timescale 1ns/10ps

module frame_control import filter_pkg::*; (
	input  logic         clk,
	input  logic         reset,

	// sink side of the stream
	input  logic         valid_in,
	input  logic         sop_in,
	input  logic         eop_in,
	input  logic [1:0]   filter_num,
	input  logic [1:0]   freq_flag,

	// stall condition from the output register
	input  logic         advance,

	output logic         ready_out,

	// beat control towards lanes and output register
	output logic         accept,
	output logic         restart,
	output logic         beat_sop,
	output logic         beat_eop,
	output filter_mode_e mode,
	output logic [1:0]   level
);

	filter_mode_e mode_q;
	logic [1:0]   level_q;

	// the whole stage moves together, so back pressure is just the stall signal
	assign ready_out = advance;

	assign accept  = valid_in && advance;
	assign restart = accept && sop_in;

	assign beat_sop = valid_in && sop_in;
	assign beat_eop = valid_in && eop_in;

	// a sop beat uses the new selection straight away
	always_comb begin
		if (restart) begin
			mode  = filter_mode_e'(filter_num);
			level = freq_flag;
		end else begin
			mode  = mode_q;
			level = level_q;
		end
	end

	// hold mode and level until the next line starts
	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q  <= COLOUR;
			level_q <= 2'd0;
		end else if (restart) begin
			mode_q  <= filter_mode_e'(filter_num);
			level_q <= freq_flag;
		end
	end

endmodule

// File: rtl/channel_filter.sv
`timescale 1ns/10ps

`include "filter_consts.svh"

module channel_filter import filter_pkg::*; (
	input  logic                         clk,
	input  logic                         reset,

	input  logic                         accept,
	input  logic                         restart,
	input  filter_mode_e                 mode,
	input  logic [1:0]                   level,

	input  logic [`FS_CHANNEL_WIDTH-1:0] chan_in,
	output logic [`FS_CHANNEL_WIDTH-1:0] chan_out
);

	logic [`FS_CHANNEL_WIDTH-1:0] prev_q;
	logic [`FS_CHANNEL_WIDTH-1:0] prev_eff;
	logic [`FS_CHANNEL_WIDTH-1:0] result;

	// inversion and brightness
	logic [`FS_CHANNEL_WIDTH-1:0] invert_val;
	logic [`FS_CHANNEL_WIDTH:0]   bright_sum;
	logic [`FS_CHANNEL_WIDTH-1:0] bright_val;

	// blur weights add up to 4
	logic [2:0]                   cur_weight;
	logic [`FS_CHANNEL_WIDTH+2:0] prev_wide;
	logic [`FS_CHANNEL_WIDTH+2:0] cur_wide;
	logic [`FS_CHANNEL_WIDTH+2:0] blur_sum;
	logic [`FS_CHANNEL_WIDTH-1:0] blur_val;

	// edge magnitude
	logic [`FS_CHANNEL_WIDTH-1:0] edge_diff;
	logic [`FS_CHANNEL_WIDTH+2:0] edge_shift;
	logic [`FS_CHANNEL_WIDTH-1:0] edge_val;

	// first pixel of a line has no left neighbour
	assign prev_eff = restart ? chan_in : prev_q;

	assign invert_val = `FS_CHANNEL_MAX - chan_in;

	always_comb begin
		bright_sum = {1'b0, chan_in} + {2'b00, level, 1'b0};
		if (bright_sum[`FS_CHANNEL_WIDTH]) begin
			bright_val = `FS_CHANNEL_MAX;
		end else begin
			bright_val = bright_sum[`FS_CHANNEL_WIDTH-1:0];
		end
	end

	always_comb begin
		cur_weight = 3'd4 - {1'b0, level};
		prev_wide  = {3'b000, prev_eff};
		cur_wide   = {3'b000, chan_in};
		blur_sum   = prev_wide * {5'b00000, level} + cur_wide * {4'b0000, cur_weight};
		// divide by 4 and round down
		blur_val   = blur_sum[`FS_CHANNEL_WIDTH+1:2];
	end

	always_comb begin
		if (chan_in >= prev_eff) begin
			edge_diff = chan_in - prev_eff;
		end else begin
			edge_diff = prev_eff - chan_in;
		end
		edge_shift = {3'b000, edge_diff} << level;
		if (edge_shift > {3'b000, `FS_CHANNEL_MAX}) begin
			edge_val = `FS_CHANNEL_MAX;
		end else begin
			edge_val = edge_shift[`FS_CHANNEL_WIDTH-1:0];
		end
	end

	always_comb begin
		result = chan_in;
		case (mode)
			COLOUR: begin
				result = invert_val;
			end
			BLUR: begin
				result = blur_val;
			end
			BRIGHTNESS: begin
				result = bright_val;
			end
			EDGES: begin
				result = edge_val;
			end
			default: begin
				result = chan_in;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prev_q   <= '0;
			chan_out <= '0;
		end else if (accept) begin
			prev_q   <= chan_in;
			chan_out <= result;
		end
	end

endmodule

// File: rtl/stream_output.sv
`timescale 1ns/10ps

module stream_output (
	input  logic clk,
	input  logic reset,

	// beat taken by the stage this cycle
	input  logic accept,
	input  logic beat_sop,
	input  logic beat_eop,

	// back pressure from the downstream sink
	input  logic ready_in,

	output logic advance,

	// source side flags
	output logic valid_out,
	output logic sop_out,
	output logic eop_out
);

	logic taken;

	// the sink takes the current output beat
	assign taken = valid_out && ready_in;

	// register can load when it is empty or being drained this cycle
	assign advance = ready_in || !valid_out;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
			sop_out   <= 1'b0;
			eop_out   <= 1'b0;
		end else if (accept) begin
			valid_out <= 1'b1;
			sop_out   <= beat_sop;
			eop_out   <= beat_eop;
		end else if (taken) begin
			// drained with nothing behind it
			valid_out <= 1'b0;
			sop_out   <= 1'b0;
			eop_out   <= 1'b0;
		end
	end

endmodule

// File: rtl/filter_select.sv
`timescale 1ns/10ps

`include "filter_consts.svh"

module filter_select import filter_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [1:0]                 freq_flag,
	input  logic [1:0]                 filter_num,

	// sink
	input  logic [`FS_PIXEL_WIDTH-1:0] data_in,
	input  logic                       sop_in,
	input  logic                       eop_in,
	input  logic                       valid_in,

	// back pressure from the next stage
	input  logic                       ready_in,

	// back pressure to the previous stage
	output logic                       ready_out,

	// source
	output logic [`FS_PIXEL_WIDTH-1:0] data_out,
	output logic                       sop_out,
	output logic                       eop_out,
	output logic                       valid_out
);

	logic         advance;
	logic         accept;
	logic         restart;
	logic         beat_sop;
	logic         beat_eop;
	filter_mode_e mode;
	logic [1:0]   level;

	// channel 0 sits in the low nibble
	logic [`FS_NUM_CHANNELS-1:0][`FS_CHANNEL_WIDTH-1:0] lane_in;
	logic [`FS_NUM_CHANNELS-1:0][`FS_CHANNEL_WIDTH-1:0] lane_out;

	assign lane_in  = data_in;
	assign data_out = lane_out;

	frame_control i_frame_control (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.sop_in     (sop_in),
		.eop_in     (eop_in),
		.filter_num (filter_num),
		.freq_flag  (freq_flag),
		.advance    (advance),
		.ready_out  (ready_out),
		.accept     (accept),
		.restart    (restart),
		.beat_sop   (beat_sop),
		.beat_eop   (beat_eop),
		.mode       (mode),
		.level      (level)
	);

	for (genvar i = 0; i < `FS_NUM_CHANNELS; i++) begin : gen_lane
		channel_filter i_lane (
			.clk      (clk),
			.reset    (reset),
			.accept   (accept),
			.restart  (restart),
			.mode     (mode),
			.level    (level),
			.chan_in  (lane_in[i]),
			.chan_out (lane_out[i])
		);
	end

	stream_output i_stream_output (
		.clk       (clk),
		.reset     (reset),
		.accept    (accept),
		.beat_sop  (beat_sop),
		.beat_eop  (beat_eop),
		.ready_in  (ready_in),
		.advance   (advance),
		.valid_out (valid_out),
		.sop_out   (sop_out),
		.eop_out   (eop_out)
	);

endmodule

// File: bench/filter_select_properties.sv
`timescale 1ns/10ps

`include "filter_consts.svh"

module filter_select_properties (
	input logic                       clk,
	input logic                       reset,
	input logic                       ready_in,
	input logic                       valid_out,
	input logic                       sop_out,
	input logic                       eop_out,
	input logic [`FS_PIXEL_WIDTH-1:0] data_out
);

	// output register comes up empty
	assert property (@(posedge clk) reset |=> !valid_out)
		else $error("valid_out high in the cycle after reset");

	// a stalled beat must not change under the sink
	assert property (@(posedge clk) disable iff (reset)
		(valid_out && !ready_in) |=>
			(valid_out && $stable(data_out) && $stable(sop_out) && $stable(eop_out)))
		else $error("output beat changed while stalled");

	assert property (@(posedge clk) disable iff (reset)
		(sop_out || eop_out) |-> valid_out)
		else $error("sop_out or eop_out high without valid_out");

endmodule

bind filter_select filter_select_properties i_properties (
	.clk       (clk),
	.reset     (reset),
	.ready_in  (ready_in),
	.valid_out (valid_out),
	.sop_out   (sop_out),
	.eop_out   (eop_out),
	.data_out  (data_out)
);

// File: bench/filter_select_tb.sv
`timescale 1ns/10ps

`include "filter_consts.svh"

module filter_select_tb import filter_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 300;

	logic                       clk;
	logic                       reset;
	logic [1:0]                 freq_flag;
	logic [1:0]                 filter_num;
	logic [`FS_PIXEL_WIDTH-1:0] data_in;
	logic                       sop_in;
	logic                       eop_in;
	logic                       valid_in;
	logic                       ready_in;
	logic                       ready_out;
	logic [`FS_PIXEL_WIDTH-1:0] data_out;
	logic                       sop_out;
	logic                       eop_out;
	logic                       valid_out;

	int unsigned seed_val;
	int          ready_low_pct;
	int          errors;
	int          tests_passed;
	int          tests_failed;
	bit          timed_out;

	// reference model state
	logic [`FS_PIXEL_WIDTH+1:0] exp_q[$];
	filter_mode_e               m_mode;
	logic [1:0]                 m_level;
	logic [`FS_PIXEL_WIDTH-1:0] m_prev;
	bit                         last_accept;
	bit                         expect_drain;

	filter_select i_dut (
		.clk        (clk),
		.reset      (reset),
		.freq_flag  (freq_flag),
		.filter_num (filter_num),
		.data_in    (data_in),
		.sop_in     (sop_in),
		.eop_in     (eop_in),
		.valid_in   (valid_in),
		.ready_in   (ready_in),
		.ready_out  (ready_out),
		.data_out   (data_out),
		.sop_out    (sop_out),
		.eop_out    (eop_out),
		.valid_out  (valid_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic int model_channel(filter_mode_e m, logic [1:0] lvl, int c, int p);
		int l;
		int r;
		l = lvl;
		r = c;
		case (m)
			COLOUR: r = 15 - c;
			BRIGHTNESS: r = c + 2 * l;
			BLUR: r = (p * l + c * (4 - l)) / 4;
			EDGES: r = ((c > p) ? (c - p) : (p - c)) * (1 << l);
			default: r = c;
		endcase
		if (r > 15) begin
			r = 15;
		end
		return r;
	endfunction

	function automatic logic [`FS_PIXEL_WIDTH-1:0] model_pixel(filter_mode_e m, logic [1:0] lvl,
			logic [`FS_PIXEL_WIDTH-1:0] cur, logic [`FS_PIXEL_WIDTH-1:0] prev);
		logic [`FS_PIXEL_WIDTH-1:0] pix;
		int c;
		int p;
		pix = '0;
		for (int ch = 0; ch < `FS_NUM_CHANNELS; ch++) begin
			c = (cur >> (ch * `FS_CHANNEL_WIDTH)) & 15;
			p = (prev >> (ch * `FS_CHANNEL_WIDTH)) & 15;
			pix = pix | (`FS_PIXEL_WIDTH'(model_channel(m, lvl, c, p)) << (ch * `FS_CHANNEL_WIDTH));
		end
		return pix;
	endfunction

	// handshakes are judged on the values present at the rising edge
	always @(posedge clk) begin
		logic [`FS_PIXEL_WIDTH+1:0] exp_beat;
		bit took_out;
		bit acc;
		if (reset) begin
			exp_q.delete();
			m_mode       = COLOUR;
			m_level      = 2'd0;
			m_prev       = '0;
			last_accept  = 1'b0;
			expect_drain = 1'b0;
		end else begin
			if (!valid_out && ready_out !== 1'b1) begin
				$display("[ERROR] %0t ready_out expected %b actual %b", $time, 1'b1, ready_out);
				errors++;
			end
			if (valid_out && ready_out !== ready_in) begin
				$display("[ERROR] %0t ready_out expected %b actual %b", $time, ready_in,
					ready_out);
				errors++;
			end
			if (last_accept && !valid_out) begin
				$display("%0t: accepted beat did not show up after one cycle", $time);
				errors++;
			end
			if (expect_drain && valid_out) begin
				$display("%0t: valid_out still high one cycle after the last beat was taken",
					$time);
				errors++;
			end
			took_out = valid_out && ready_in;
			acc      = valid_in && ready_out;
			if (took_out) begin
				if (exp_q.size() == 0) begin
					$display("%0t: output beat taken with no beat expected", $time);
					errors++;
				end else begin
					exp_beat = exp_q.pop_front();
					if (data_out !== exp_beat[`FS_PIXEL_WIDTH-1:0]) begin
						$display("[ERROR] %0t data_out expected %h actual %h", $time,
							exp_beat[`FS_PIXEL_WIDTH-1:0], data_out);
						errors++;
					end
					if (sop_out !== exp_beat[`FS_PIXEL_WIDTH+1]) begin
						$display("[ERROR] %0t sop_out expected %b actual %b", $time,
							exp_beat[`FS_PIXEL_WIDTH+1], sop_out);
						errors++;
					end
					if (eop_out !== exp_beat[`FS_PIXEL_WIDTH]) begin
						$display("[ERROR] %0t eop_out expected %b actual %b", $time,
							exp_beat[`FS_PIXEL_WIDTH], eop_out);
						errors++;
					end
				end
			end
			if (acc) begin
				// a new line takes the selection and starts without a left neighbour
				if (sop_in) begin
					m_mode  = filter_mode_e'(filter_num);
					m_level = freq_flag;
					m_prev  = data_in;
				end
				exp_q.push_back({sop_in, eop_in, model_pixel(m_mode, m_level, data_in, m_prev)});
				m_prev = data_in;
			end
			last_accept  = acc;
			expect_drain = took_out && !acc;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
		ready_in = ($urandom_range(99) >= ready_low_pct);
	endtask

	task automatic drive_beat(logic [`FS_PIXEL_WIDTH-1:0] pix, logic sop, logic eop,
			logic [1:0] fnum, logic [1:0] flag);
		int  waited;
		bit  took;
		waited     = 0;
		took       = 1'b0;
		data_in    = pix;
		sop_in     = sop;
		eop_in     = eop;
		filter_num = fnum;
		freq_flag  = flag;
		valid_in   = 1'b1;
		while (!took && !timed_out) begin
			@(posedge clk);
			took = ready_out;
			#1;
			ready_in = ($urandom_range(99) >= ready_low_pct);
			waited++;
			if (!took && waited >= TIMEOUT_CYCLES) begin
				$display("timeout: input beat was never accepted by the DUT");
				timed_out = 1'b1;
			end
		end
		valid_in = 1'b0;
	endtask

	// idle input with junk on the data and control lines
	task automatic idle(int n, bit scramble);
		valid_in = 1'b0;
		for (int i = 0; i < n; i++) begin
			data_in = $urandom_range(4095);
			sop_in  = $urandom_range(1);
			eop_in  = $urandom_range(1);
			if (scramble) begin
				filter_num = $urandom_range(3);
				freq_flag  = $urandom_range(3);
			end
			next_cycle();
		end
	endtask

	task automatic send_packet(filter_mode_e m, logic [1:0] lvl, bit scramble);
		int         len;
		logic [1:0] fnum;
		logic [1:0] flag;
		len = $urandom_range(12, 4);
		for (int i = 0; i < len && !timed_out; i++) begin
			if (i > 0 && $urandom_range(3) == 0) begin
				idle($urandom_range(3, 1), scramble);
			end
			fnum = m;
			flag = lvl;
			if (scramble && i > 0) begin
				fnum = $urandom_range(3);
				flag = $urandom_range(3);
			end
			drive_beat($urandom_range(4095), i == 0, i == len - 1, fnum, flag);
		end
		idle($urandom_range(2), scramble);
	endtask

	task automatic wait_drained();
		int waited;
		waited        = 0;
		ready_low_pct = 0;
		valid_in      = 1'b0;
		while (!timed_out && (exp_q.size() != 0 || valid_out)) begin
			next_cycle();
			waited++;
			if (waited >= TIMEOUT_CYCLES) begin
				$display("timeout: output did not drain, %0d beats still expected", exp_q.size());
				timed_out = 1'b1;
			end
		end
		idle(3, 1'b0);
		ready_low_pct = 30;
	endtask

	task automatic finish_test(string name, int errors_before);
		wait_drained();
		if (errors == errors_before && !timed_out) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: failed with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	task automatic run_single_mode(string name, filter_mode_e m, int per_level);
		int errors_before;
		errors_before = errors;
		for (int lvl = 0; lvl < 4; lvl++) begin
			for (int k = 0; k < per_level; k++) begin
				send_packet(m, lvl, 1'b0);
			end
		end
		finish_test(name, errors_before);
	endtask

	task automatic run_random_modes(string name, int packets, bit scramble);
		int errors_before;
		errors_before = errors;
		for (int k = 0; k < packets; k++) begin
			send_packet(filter_mode_e'($urandom_range(3)), $urandom_range(3), scramble);
			if ($urandom_range(2) == 0) begin
				idle($urandom_range(6, 2), scramble);
			end
		end
		finish_test(name, errors_before);
	endtask

	initial begin
		seed_val      = $urandom(32'h4c3390e0);
		ready_low_pct = 30;
		errors        = 0;
		tests_passed  = 0;
		tests_failed  = 0;
		timed_out     = 1'b0;
		reset         = 1'b1;
		freq_flag     = 2'd0;
		filter_num    = 2'd0;
		data_in       = '0;
		sop_in        = 1'b0;
		eop_in        = 1'b0;
		valid_in      = 1'b0;
		ready_in      = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		run_single_mode("inversion", COLOUR, 1);
		run_single_mode("brightness", BRIGHTNESS, 2);
		run_single_mode("blur", BLUR, 2);
		run_single_mode("edges", EDGES, 2);
		run_random_modes("mode_latch", 8, 1'b1);
		run_random_modes("backpressure", 14, 1'b0);

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0 && !timed_out) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+rtl
rtl/filter_pkg.sv
rtl/frame_control.sv
rtl/channel_filter.sv
rtl/stream_output.sv
rtl/filter_select.sv
bench/filter_select_properties.sv
bench/filter_select_tb.sv

// File: Bender.yml
package:
  name: filter_select

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/filter_pkg.sv
      - rtl/frame_control.sv
      - rtl/channel_filter.sv
      - rtl/stream_output.sv
      - rtl/filter_select.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/filter_select_properties.sv
      - bench/filter_select_tb.sv
